// ==== src/vdp_timing_pkg.sv ====
/*
 * Video mode constants and raster types for the 640x480 60 Hz mode.
 * Imported by the raster timing generator and by every block that
 * carries raster positions.
 */
package vdp_timing_pkg;

    // Horizontal, in pixel clocks. Blanking comes first on each line
    localparam int H_ACTIVE_WIDTH = 640;
    localparam int H_FRONTPORCH = 16;
    localparam int H_SYNC = 96;
    localparam int H_BACKPORCH = 48;

    localparam int H_OFFSCREEN_TOTAL = H_FRONTPORCH + H_SYNC + H_BACKPORCH;
    localparam int H_TOTAL = H_OFFSCREEN_TOTAL + H_ACTIVE_WIDTH;

    // Vertical, in lines. Active lines come first in each frame
    localparam int V_ACTIVE_HEIGHT = 480;
    localparam int V_FRONTPORCH = 11;
    localparam int V_SYNC = 2;
    localparam int V_BACKPORCH = 31;

    localparam int V_TOTAL = V_ACTIVE_HEIGHT + V_FRONTPORCH + V_SYNC + V_BACKPORCH;

    // Sync windows, start inclusive and end exclusive
    localparam int HSYNC_START = H_FRONTPORCH;
    localparam int HSYNC_END = H_FRONTPORCH + H_SYNC;

    localparam int VSYNC_START = V_ACTIVE_HEIGHT + V_FRONTPORCH;
    localparam int VSYNC_END = VSYNC_START + V_SYNC;

    // Horizontal position within a line
    typedef logic [11:0] raster_x_t;

    // Line number within a frame
    typedef logic [10:0] raster_y_t;

endpackage

// ==== src/vdp_regs_pkg.sv ====
/*
 * Host register map and the data types of the host, VRAM and palette
 * paths. Imported by the register bank, the color stage and the top.
 */
package vdp_regs_pkg;

    // Host side
    typedef logic [4:0] reg_addr_t;
    typedef logic [15:0] host_data_t;

    // Writable registers
    localparam reg_addr_t REG_PALETTE_ADDRESS = 5'd2;
    localparam reg_addr_t REG_PALETTE_DATA = 5'd3;
    localparam reg_addr_t REG_VRAM_ADDRESS = 5'd4;
    localparam reg_addr_t REG_VRAM_DATA = 5'd5;
    localparam reg_addr_t REG_VRAM_INCREMENT = 5'd6;

    // Address bit choosing raster_y over raster_x on readback
    localparam int REG_READ_RASTER_Y_BIT = 1;

    // VRAM addressing
    // Full address counts 16-bit words over both banks, bit 0 picks the bank
    typedef logic [14:0] vram_full_address_t;

    // Word address inside a single bank
    typedef logic [13:0] vram_address_t;

    // Palette
    typedef logic [7:0] palette_index_t;

    // Low 12 bits hold RGB444, upper 4 bits are stored but not shown
    typedef logic [15:0] palette_color_t;

    // One channel of the RGB444 output
    typedef logic [3:0] color_channel_t;

    // Transparent pixels resolve to this entry
    localparam palette_index_t BACKDROP_INDEX = 8'd0;

endpackage

// ==== src/vdp_raster_timing.sv ====
/*
 * Raster timing generator for 640x480. Keeps the beam position, drives
 * the sync outputs and the active display level, and gives one-cycle
 * strobes at line end, frame end and the end of the visible frame.
 */
module vdp_raster_timing
    import vdp_timing_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    output raster_x_t raster_x,
    output raster_y_t raster_y,

    output logic      hsync,
    output logic      vsync,
    output logic      active_display,

    // Single-cycle strobes, not meant to drive a monitor
    output logic      line_ended,
    output logic      frame_ended,
    output logic      active_frame_ended
);

    raster_x_t next_x;
    raster_y_t next_y;

    // Strobes decode the current position directly
    assign line_ended = raster_x == raster_x_t'(H_TOTAL - 1);
    assign frame_ended = line_ended && raster_y == raster_y_t'(V_TOTAL - 1);
    assign active_frame_ended = line_ended && raster_y == raster_y_t'(V_ACTIVE_HEIGHT - 1);

    // Position for the next clock
    always_comb begin
        next_x = raster_x + 1'b1;
        next_y = raster_y;

        if (line_ended) begin
            next_x = '0;
            next_y = frame_ended ? '0 : raster_y + 1'b1;
        end
    end

    // Sync and active levels are decoded from the next position,
    // so the registered outputs line up with the counters
    always_ff @(posedge clk) begin
        if (reset) begin
            raster_x <= '0;
            raster_y <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
            active_display <= 1'b0;
        end else begin
            raster_x <= next_x;
            raster_y <= next_y;

            // Both syncs active low
            hsync <= !(next_x >= raster_x_t'(HSYNC_START)
                && next_x < raster_x_t'(HSYNC_END));
            vsync <= !(next_y >= raster_y_t'(VSYNC_START)
                && next_y < raster_y_t'(VSYNC_END));

            active_display <= next_x >= raster_x_t'(H_OFFSCREEN_TOTAL)
                && next_y < raster_y_t'(V_ACTIVE_HEIGHT);
        end
    end

endmodule

// ==== src/vdp_register_bank.sv ====
/*
 * Host register bank. Decodes host writes into the palette address and
 * the VRAM address, data and increment registers, runs the one-cycle
 * VRAM write onto the even or odd bank and registers raster readback.
 */
module vdp_register_bank
    import vdp_timing_pkg::*;
    import vdp_regs_pkg::*;
(
    input  logic           clk,
    input  logic           reset,

    // Host side
    input  reg_addr_t      host_address,
    input  host_data_t     host_write_data,
    input  logic           host_write_en,
    input  logic           host_read_en,
    output host_data_t     host_read_data,
    output logic           host_ready,

    // Current beam position for readback
    input  raster_x_t      raster_x,
    input  raster_y_t      raster_y,

    // Palette write port
    output logic           palette_write_en,
    output palette_index_t palette_write_address,
    output palette_color_t palette_write_data,

    // VRAM write ports
    output vram_address_t  vram_address_even,
    output logic           vram_we_even,
    output host_data_t     vram_write_data_even,

    output vram_address_t  vram_address_odd,
    output logic           vram_we_odd,
    output host_data_t     vram_write_data_odd
);

    palette_index_t palette_address;

    vram_full_address_t vram_full_address;
    vram_full_address_t vram_increment;
    host_data_t vram_data;
    logic vram_pending;

    logic vram_write_accept;

    // Only one VRAM write in flight, a second one is dropped
    assign host_ready = !vram_pending;
    assign vram_write_accept = host_write_en && host_address == REG_VRAM_DATA && host_ready;

    // Palette data goes straight through to the RAM in the strobe cycle
    assign palette_write_en = host_write_en && host_address == REG_PALETTE_DATA;
    assign palette_write_address = palette_address;
    assign palette_write_data = palette_color_t'(host_write_data);

    // Bank select from the low bit of the word address
    assign vram_we_even = vram_pending && !vram_full_address[0];
    assign vram_we_odd = vram_pending && vram_full_address[0];

    assign vram_address_even = vram_full_address[14:1];
    assign vram_address_odd = vram_full_address[14:1];

    assign vram_write_data_even = vram_data;
    assign vram_write_data_odd = vram_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            palette_address <= '0;
            vram_full_address <= '0;
            vram_increment <= '0;
            vram_pending <= 1'b0;
        end else begin
            // Write completes in its single pending cycle
            if (vram_pending) begin
                vram_pending <= 1'b0;
                vram_full_address <= vram_full_address + vram_increment;
            end

            // Auto-increment, wraps at 255
            if (palette_write_en) begin
                palette_address <= palette_address + 1'b1;
            end

            // Explicit address writes override the steps above
            if (host_write_en) begin
                case (host_address)
                    REG_PALETTE_ADDRESS: palette_address <= palette_index_t'(host_write_data);
                    REG_VRAM_ADDRESS: vram_full_address <= vram_full_address_t'(host_write_data);
                    REG_VRAM_DATA: vram_pending <= host_ready;
                    REG_VRAM_INCREMENT: vram_increment <= vram_full_address_t'(host_write_data);
                    default: begin
                        // Palette data is handled above, other addresses ignored
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (vram_write_accept) begin
            vram_data <= host_write_data;
        end
    end

    // Readback is sampled every cycle, host_read_en is not needed for it
    always_ff @(posedge clk) begin
        if (host_address[REG_READ_RASTER_Y_BIT]) begin
            host_read_data <= host_data_t'(raster_y);
        end else begin
            host_read_data <= host_data_t'(raster_x);
        end
    end

endmodule

// ==== src/vdp_color_output.sv ====
/*
 * Color output stage. Holds the 256-entry palette and shows the backdrop
 * entry during active display, black elsewhere. The RGB outputs trail
 * active_display by two clocks.
 */
module vdp_color_output
    import vdp_regs_pkg::*;
(
    input  logic           clk,

    input  logic           active_display,

    // Palette write port
    input  logic           palette_write_en,
    input  palette_index_t palette_write_address,
    input  palette_color_t palette_write_data,

    // RGB444 out
    output color_channel_t r,
    output color_channel_t g,
    output color_channel_t b
);

    palette_color_t palette_ram [256];
    palette_color_t backdrop_color;

    logic active_display_d;

    // One write port, one read port
    always_ff @(posedge clk) begin
        if (palette_write_en) begin
            palette_ram[palette_write_address] <= palette_write_data;
        end

        // No layers left, every pixel is the backdrop
        backdrop_color <= palette_ram[BACKDROP_INDEX];
    end

    // Match the palette read latency
    always_ff @(posedge clk) begin
        active_display_d <= active_display;
    end

    // Blanking forces black outside the visible area
    always_ff @(posedge clk) begin
        if (active_display_d) begin
            r <= backdrop_color[11:8];
            g <= backdrop_color[7:4];
            b <= backdrop_color[3:0];
        end else begin
            r <= '0;
            g <= '0;
            b <= '0;
        end
    end

endmodule

// ==== src/vdp.sv ====
/*
 * Top of the display core. Raster timing and the host register bank run
 * side by side and the color stage combines their results into RGB.
 * Drive clk and reset, then talk to the host port.
 */
module vdp
    import vdp_timing_pkg::*;
    import vdp_regs_pkg::*;
(
    input  logic           clk,
    input  logic           reset,

    // Host interface
    input  reg_addr_t      host_address,
    input  host_data_t     host_write_data,
    input  logic           host_write_en,
    input  logic           host_read_en,
    output host_data_t     host_read_data,
    output logic           host_ready,

    // VGA output
    output color_channel_t r,
    output color_channel_t g,
    output color_channel_t b,

    output logic           vga_hsync,
    output logic           vga_vsync,
    output logic           active_display,

    // Single-cycle strobes
    output logic           line_ended,
    output logic           frame_ended,
    output logic           active_frame_ended,

    // VRAM write ports
    output vram_address_t  vram_address_even,
    output logic           vram_we_even,
    output host_data_t     vram_write_data_even,

    output vram_address_t  vram_address_odd,
    output logic           vram_we_odd,
    output host_data_t     vram_write_data_odd
);

    raster_x_t raster_x;
    raster_y_t raster_y;

    logic palette_write_en;
    palette_index_t palette_write_address;
    palette_color_t palette_write_data;

    vdp_raster_timing u_raster_timing (
        .clk                (clk),
        .reset              (reset),
        .raster_x           (raster_x),
        .raster_y           (raster_y),
        .hsync              (vga_hsync),
        .vsync              (vga_vsync),
        .active_display     (active_display),
        .line_ended         (line_ended),
        .frame_ended        (frame_ended),
        .active_frame_ended (active_frame_ended)
    );

    vdp_register_bank u_register_bank (
        .clk                   (clk),
        .reset                 (reset),
        .host_address          (host_address),
        .host_write_data       (host_write_data),
        .host_write_en         (host_write_en),
        .host_read_en          (host_read_en),
        .host_read_data        (host_read_data),
        .host_ready            (host_ready),
        .raster_x              (raster_x),
        .raster_y              (raster_y),
        .palette_write_en      (palette_write_en),
        .palette_write_address (palette_write_address),
        .palette_write_data    (palette_write_data),
        .vram_address_even     (vram_address_even),
        .vram_we_even          (vram_we_even),
        .vram_write_data_even  (vram_write_data_even),
        .vram_address_odd      (vram_address_odd),
        .vram_we_odd           (vram_we_odd),
        .vram_write_data_odd   (vram_write_data_odd)
    );

    vdp_color_output u_color_output (
        .clk                   (clk),
        .active_display        (active_display),
        .palette_write_en      (palette_write_en),
        .palette_write_address (palette_write_address),
        .palette_write_data    (palette_write_data),
        .r                     (r),
        .g                     (g),
        .b                     (b)
    );

endmodule

// ==== verif/vdp_tb.sv ====
/*
 * Directed testbench for the display core. Checks reset state, raster
 * timing, palette backdrop, VRAM writes and raster readback on vdp.
 * Built and run with Verilator through the Makefile.
 */
module vdp_tb
    import vdp_regs_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LINE_TIMEOUT = 1000;
    localparam int FRAME_TIMEOUT = 450000;
    localparam int READY_TIMEOUT = 16;
    localparam int PALETTE_CHECK_CYCLES = 1600;
    localparam int READBACK_CYCLES = 2500;
    localparam logic [31:0] LCG_SEED = 32'h7159;

    // Bit 1 of the address picks raster_y
    localparam reg_addr_t READ_Y_ADDRESS = 5'd2;
    localparam reg_addr_t READ_X_ADDRESS = 5'd1;

    logic clk;
    logic reset;
    reg_addr_t host_address;
    host_data_t host_write_data;
    logic host_write_en;
    logic host_read_en;
    host_data_t host_read_data;
    logic host_ready;
    color_channel_t r;
    color_channel_t g;
    color_channel_t b;
    logic vga_hsync;
    logic vga_vsync;
    logic active_display;
    logic line_ended;
    logic frame_ended;
    logic active_frame_ended;
    vram_address_t vram_address_even;
    logic vram_we_even;
    host_data_t vram_write_data_even;
    vram_address_t vram_address_odd;
    logic vram_we_odd;
    host_data_t vram_write_data_odd;

    logic [31:0] lcg_state;

    vdp u_vdp (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            fail_now($sformatf("Fail %s got 0x%h expected 0x%h", name, got, expected));
        end
    endtask

    // One-cycle host write strobe that returns just after the next edge
    task automatic drive_write(input reg_addr_t address, input host_data_t data);
        @(posedge clk);
        #1;
        host_address = address;
        host_write_data = data;
        host_write_en = 1'b1;
        @(posedge clk);
        #1;
        host_write_en = 1'b0;
    endtask

    task automatic wait_line_end();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!line_ended && cycles < LINE_TIMEOUT);
        assert (line_ended) else fail_now("Timed out waiting for line_ended");
    endtask

    task automatic wait_frame_end();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!frame_ended && cycles < FRAME_TIMEOUT);
        assert (frame_ended) else fail_now("Timed out waiting for frame_ended");
    endtask

    task automatic wait_host_ready();
        int cycles;
        cycles = 0;
        while (!host_ready && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (host_ready) else fail_now("Timed out waiting for host_ready");
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_value("host_ready", 32'(host_ready), 32'd1);
        check_value("vram_we_even", 32'(vram_we_even), 32'd0);
        check_value("vram_we_odd", 32'(vram_we_odd), 32'd0);
        check_value("rgb", 32'({r, g, b}), 32'd0);
    endtask

    task automatic test_line_timing();
        int cycles;
        int hsync_low;
        int active_cycles;
        wait_line_end();
        cycles = 0;
        hsync_low = 0;
        active_cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (!vga_hsync) hsync_low++;
            if (active_display) active_cycles++;
        end while (!line_ended && cycles < LINE_TIMEOUT);
        check_value("line_ended period", 32'(cycles), 32'd800);
        check_value("vga_hsync low cycles", 32'(hsync_low), 32'd96);
        // Line right after reset is a visible one
        check_value("active_display cycles", 32'(active_cycles), 32'd640);
    endtask

    task automatic test_frame_timing();
        int lines;
        int active_end_line;
        int active_ends;
        int cycles;
        int vsync_low;
        int active_cycles;
        wait_frame_end();
        lines = 0;
        active_end_line = 0;
        active_ends = 0;
        cycles = 0;
        vsync_low = 0;
        active_cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (!vga_vsync) vsync_low++;
            if (active_display) active_cycles++;
            if (line_ended) lines++;
            if (active_frame_ended) begin
                active_ends++;
                active_end_line = lines;
            end
        end while (!frame_ended && cycles < FRAME_TIMEOUT);
        assert (frame_ended) else fail_now("Timed out waiting for the next frame_ended");
        check_value("line_ended count", 32'(lines), 32'd524);
        check_value("active_frame_ended count", 32'(active_ends), 32'd1);
        check_value("active_frame_ended lead", 32'(lines - active_end_line), 32'd44);
        // Two sync lines of 800 clocks each
        check_value("vga_vsync low cycles", 32'(vsync_low), 32'd1600);
        check_value("active_display frame cycles", 32'(active_cycles), 32'(640 * 480));
    endtask

    task automatic test_palette();
        logic [31:0] word;
        host_data_t first_color;
        host_data_t second_color;
        logic active_d1;
        logic active_d2;
        logic [11:0] expected;
        int active_checks;
        word = next_random();
        first_color = word[31:16];
        word = next_random();
        second_color = word[31:16];
        // Second color wraps around to the backdrop entry
        drive_write(REG_PALETTE_ADDRESS, 16'd255);
        drive_write(REG_PALETTE_DATA, first_color);
        drive_write(REG_PALETTE_DATA, second_color);
        active_d1 = 1'b0;
        active_d2 = 1'b0;
        repeat (3) begin
            @(negedge clk);
            active_d2 = active_d1;
            active_d1 = active_display;
        end
        active_checks = 0;
        repeat (PALETTE_CHECK_CYCLES) begin
            @(negedge clk);
            expected = active_d2 ? second_color[11:0] : 12'h000;
            if (active_d2) active_checks++;
            check_value("rgb", 32'({r, g, b}), 32'(expected));
            active_d2 = active_d1;
            active_d1 = active_display;
        end
        assert (active_checks > 0) else fail_now("No active display seen in the palette test");
    endtask

    // Checks the single pending cycle and the one after it
    task automatic check_vram_write(input logic odd, input vram_full_address_t address,
                                    input host_data_t data);
        @(negedge clk);
        check_value("host_ready", 32'(host_ready), 32'd0);
        check_value("vram_we_even", 32'(vram_we_even), 32'(!odd));
        check_value("vram_we_odd", 32'(vram_we_odd), 32'(odd));
        if (odd) begin
            check_value("vram_address_odd", 32'(vram_address_odd), 32'(address >> 1));
            check_value("vram_write_data_odd", 32'(vram_write_data_odd), 32'(data));
        end else begin
            check_value("vram_address_even", 32'(vram_address_even), 32'(address >> 1));
            check_value("vram_write_data_even", 32'(vram_write_data_even), 32'(data));
        end
        @(negedge clk);
        check_value("host_ready", 32'(host_ready), 32'd1);
        check_value("vram_we_even", 32'(vram_we_even), 32'd0);
        check_value("vram_we_odd", 32'(vram_we_odd), 32'd0);
    endtask

    task automatic test_vram();
        logic [31:0] word;
        vram_full_address_t first_address;
        vram_full_address_t second_address;
        host_data_t first_data;
        host_data_t second_data;
        word = next_random();
        first_address = {word[29:16], 1'b0};
        second_address = first_address + 15'd3;
        word = next_random();
        first_data = word[31:16];
        word = next_random();
        second_data = word[31:16];
        drive_write(REG_VRAM_ADDRESS, host_data_t'(first_address));
        drive_write(REG_VRAM_INCREMENT, 16'd3);
        drive_write(REG_VRAM_DATA, first_data);
        check_vram_write(1'b0, first_address, first_data);
        wait_host_ready();
        drive_write(REG_VRAM_DATA, second_data);
        check_vram_write(1'b1, second_address, second_data);
    endtask

    task automatic test_readback();
        int line_count;
        int prev_line;
        host_data_t prev_value;
        logic ended_d1;
        logic ended_d2;
        @(posedge clk);
        #1;
        host_address = READ_Y_ADDRESS;
        host_read_en = 1'b1;
        wait_frame_end();
        // Readback trails by one cycle, so track the previous line
        line_count = 0;
        @(negedge clk);
        prev_line = line_count;
        repeat (READBACK_CYCLES) begin
            @(negedge clk);
            check_value("host_read_data", 32'(host_read_data), 32'(prev_line));
            prev_line = line_count;
            if (line_ended) line_count++;
        end
        @(posedge clk);
        #1;
        host_address = READ_X_ADDRESS;
        @(negedge clk);
        ended_d1 = line_ended;
        @(negedge clk);
        prev_value = host_read_data;
        ended_d2 = ended_d1;
        ended_d1 = line_ended;
        repeat (READBACK_CYCLES) begin
            @(negedge clk);
            if (!ended_d2) begin
                check_value("host_read_data", 32'(host_read_data), 32'(prev_value) + 32'd1);
            end
            prev_value = host_read_data;
            ended_d2 = ended_d1;
            ended_d1 = line_ended;
        end
        host_read_en = 1'b0;
    endtask

    initial begin
        lcg_state = LCG_SEED;
        reset = 1'b1;
        host_address = '0;
        host_write_data = '0;
        host_write_en = 1'b0;
        host_read_en = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_line_timing();
        test_frame_timing();
        test_palette();
        test_vram();
        test_readback();
        $display("test passed");
        $finish;
    end

endmodule

// ==== vdp.f ====
src/vdp_timing_pkg.sv
src/vdp_regs_pkg.sv
src/vdp_raster_timing.sv
src/vdp_register_bank.sv
src/vdp_color_output.sv
src/vdp.sv
verif/vdp_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module vdp_tb -Mdir obj_dir -f vdp.f
	@out=$$(./obj_dir/Vvdp_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "test passed"

clean:
	rm -rf obj_dir
